// File: spi_load_if.sv
`default_nettype none

// One decoded TX write, decoder to a single channel
interface spi_load_if;

   logic                      load;      // One-cycle strobe
   logic [spi_pkg::DSW-1:0]   datasize;  // Bytes to emit
   logic [spi_pkg::TXW-1:0]   tx_data;   // LSB byte goes first
   logic                      busy;      // Serializer still draining

   modport decoder (
      output load, datasize, tx_data,
      input  busy
   );

   modport channel (
      input  load, datasize, tx_data,
      output busy
   );

endinterface

`default_nettype wire

// File: spi_master_tx.sv
`default_nettype none

module spi_master_tx #(
   parameter int NCH    = 4,
   parameter int DEPTH  = 16,
   parameter int CLKDIV = 2
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     spi_en,
   input  logic                     access_in,
   input  logic [spi_pkg::PW-1:0]   packet_in,
   output logic                     wait_out,
   output logic                     sclk,
   output logic                     mosi,
   output logic [NCH-1:0]           cs_n
);

   spi_load_if ld [NCH] ();                      // Decoder to channels

   logic [NCH-1:0]            fifo_empty;
   logic [NCH-1:0]            fifo_read;
   logic [spi_pkg::SW-1:0]    fifo_dout [NCH];

   //############################################################
   // Core side
   //############################################################
   spi_tx_decode #(
      .NCH (NCH)
   ) u_decode (
      .clk       (clk),
      .rst       (rst),
      .spi_en    (spi_en),
      .access_in (access_in),
      .packet_in (packet_in),
      .wait_out  (wait_out),
      .ld        (ld)
   );

   // One serializer and FIFO per chip select
   for (genvar g = 0; g < NCH; g++) begin : g_ch
      spi_tx_channel #(
         .DEPTH (DEPTH)
      ) u_channel (
         .clk        (clk),
         .rst        (rst),
         .ld         (ld[g]),
         .fifo_read  (fifo_read[g]),
         .fifo_empty (fifo_empty[g]),
         .fifo_dout  (fifo_dout[g])
      );
   end

   // SPI pins
   spi_shift_engine #(
      .NCH    (NCH),
      .CLKDIV (CLKDIV)
   ) u_engine (
      .clk        (clk),
      .rst        (rst),
      .fifo_empty (fifo_empty),
      .fifo_dout  (fifo_dout),
      .fifo_read  (fifo_read),
      .sclk       (sclk),
      .mosi       (mosi),
      .cs_n       (cs_n)
   );

endmodule

`default_nettype wire

// File: spi_master_tx_tb.sv
`default_nettype none

module spi_master_tx_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int NCH    = 4;
   localparam int CLKDIV = 2;
   localparam int NPKT   = 256;                            // Packets over all tests
   localparam longint WD_CLK = longint'(NPKT) * 8 * (16*CLKDIV + 2) + 2000;

   logic             clk;
   logic             rst;
   logic             spi_en;
   logic             access_in;
   logic [103:0]     packet_in;
   logic             wait_out;
   logic             sclk;
   logic             mosi;
   logic [NCH-1:0]   cs_n;

   logic [7:0]       exp_q [NCH][$];   // Expected bytes per channel
   realtime          rdy_q [NCH][$];   // Latest time each byte is in its FIFO
   int               errors;
   int               tests;
   int               bytes_checked;
   int               cs_falls;
   logic             stalled;          // wait_out seen high

   // Bus monitor state
   logic [NCH-1:0]   prev_cs;
   logic             prev_sclk;
   logic [7:0]       rx_byte;
   int               nbits;
   int               cur_ch;
   int               last_ch;

   spi_master_tx u_dut (
      .clk       (clk),
      .rst       (rst),
      .spi_en    (spi_en),
      .access_in (access_in),
      .packet_in (packet_in),
      .wait_out  (wait_out),
      .sclk      (sclk),
      .mosi      (mosi),
      .cs_n      (cs_n)
   );

   always #4 clk = ~clk;                                   // 8 ns period

   initial begin
      #(WD_CLK * 8);
      $display("Watchdog expired after %0d clk, traffic never drained", WD_CLK);
      $display("Test failed");
      $finish;
   end

   //############################################################
   // Model helpers
   //############################################################
   // write, datamode, ctrlmode, dstaddr, srcaddr, data from bit 0 up
   function automatic logic [103:0] make_packet(input logic wr, input logic [1:0] dm,
         input logic [4:0] cm, input logic [31:0] dst, input logic [31:0] src,
         input logic [31:0] data);
      return {data, src, dst, cm, dm, wr};
   endfunction

   function automatic int pending();
      int n;
      n = 0;
      for (int i = 0; i < NCH; i++) begin
         n += exp_q[i].size();
      end
      return n;
   endfunction

   // Called at edge+1, returns at edge+1 with access_in still high
   task automatic send(input logic en, input logic wr, input logic [5:0] offs, input int ch,
         input logic [1:0] dm, input logic [31:0] src, input logic [31:0] data);
      logic [31:0]   dst;
      logic [63:0]   pay;
      logic          valid;
      realtime       acc;
      dst       = $urandom();
      dst[9:8]  = ch[1:0];                                 // Channel field
      dst[5:0]  = offs;
      pay       = {src, data};                             // data bytes first
      valid     = en & wr & (offs == 6'h10);
      spi_en    = en;
      access_in = 1'b1;
      packet_in = make_packet(wr, dm, 5'($urandom()), dst, src, data);
      #1;
      while (wait_out) begin                               // Core holds the packet
         stalled = 1'b1;
         assert (valid) else begin
            errors++;
            $display("wait_out rose for a dropped packet at %0t", $time);
         end
         @(posedge clk);
         #2;
      end
      @(posedge clk);                                      // Taken here
      acc = $realtime;
      #1;
      if (valid) begin
         for (int i = 0; i < (1 << dm); i++) begin
            exp_q[ch].push_back(pay[8*i +: 8]);
            rdy_q[ch].push_back(acc + 8*(i+1));            // One FIFO write per clk
         end
      end
   endtask

   task automatic rand_send(input bit allow_bad);
      logic          en;
      logic          wr;
      logic [5:0]    offs;
      en   = 1'b1;
      wr   = 1'b1;
      offs = 6'h10;
      if (allow_bad && ($urandom % 5) == 0) begin          // About one in five dropped
         case ($urandom % 3)
            0:       en = 1'b0;
            1:       wr = 1'b0;
            default: offs = 6'h10 ^ 6'(1 + $urandom % 63);
         endcase
      end
      send(en, wr, offs, $urandom % NCH, 2'($urandom), $urandom, $urandom);
   endtask

   task automatic idle();
      access_in = 1'b0;
      @(posedge clk);
      #1;
   endtask

   // Returns at edge+1 once the bus has gone quiet
   task automatic drain();
      int quiet;
      quiet     = 0;
      access_in = 1'b0;
      while (quiet < 40) begin                             // Far above any gap between bytes
         @(posedge clk);
         #1;
         if (cs_n == '1) begin
            quiet++;
         end else begin
            quiet = 0;
         end
      end
   endtask

   task automatic test_done(input string name, input int err0);
      tests++;
      $display("[%0t] %-28s %s", $time, name, (errors == err0) ? "PASS" : "FAIL");
   endtask

   //############################################################
   // SPI bus monitor, sampled mid-cycle
   //############################################################
   // Channels between the last grant and this one must not hold a ready byte
   task automatic check_fair(input int c);
      int k;
      for (int i = 1; i < NCH; i++) begin
         k = (last_ch + i) % NCH;
         if (k == c) begin
            break;
         end
         assert (exp_q[k].size() == 0 || rdy_q[k][0] + 16 >= $realtime) else begin
            errors++;
            $display("Round robin passed over channel %0d for channel %0d at %0t",
                     k, c, $time);
         end
      end
   endtask

   task automatic check_byte(input int c, input logic [7:0] got);
      logic [7:0] exp;
      assert (exp_q[c].size() > 0) else begin
         errors++;
         $display("Unexpected byte %02h under cs_n[%0d] at %0t", got, c, $time);
      end
      if (exp_q[c].size() > 0) begin
         exp = exp_q[c].pop_front();
         rdy_q[c].delete(0);
         bytes_checked++;
         assert (got == exp) else begin
            errors++;
            $display("ERROR %0t mosi byte on cs_n[%0d]: got %02h expected %02h",
                     $time, c, got, exp);
         end
      end
   endtask

   always @(negedge clk) begin
      if ((prev_cs & ~cs_n) != '0) begin                   // New grant
         cs_falls++;
         assert ($countones(~cs_n) == 1) else begin
            errors++;
            $display("Several chip selects low together at %0t", $time);
         end
         for (int i = 0; i < NCH; i++) begin
            if (!cs_n[i]) begin
               cur_ch = i;
            end
         end
         check_fair(cur_ch);
         last_ch = cur_ch;
         nbits   = 0;
      end
      if (sclk && !prev_sclk) begin                        // Receiver samples here
         assert (cs_n != '1) else begin
            errors++;
            $display("SCLK rose with no chip select low at %0t", $time);
         end
         if (cs_n != '1) begin
            rx_byte = {rx_byte[6:0], mosi};                // MSB arrives first
            nbits++;
            if (nbits == 8) begin
               check_byte(cur_ch, rx_byte);
               nbits = 0;
            end
         end
      end
      prev_cs   = cs_n;
      prev_sclk = sclk;
   end

   //############################################################
   // Tests
   //############################################################
   initial begin
      int err0;
      int falls0;
      void'($urandom(95));
      clk = 1'b0;
      rst = 1'b1;
      spi_en = 1'b1;
      access_in = 1'b0;
      packet_in = '0;
      errors = 0;
      tests = 0;
      bytes_checked = 0;
      cs_falls = 0;
      stalled = 1'b0;
      prev_cs = '1;
      prev_sclk = 1'b0;
      rx_byte = '0;
      nbits = 0;
      cur_ch = 0;
      last_ch = NCH - 1;                                   // Channel 0 served first
      repeat (3) @(posedge clk);
      #1 rst = 1'b0;

      err0 = errors;
      @(posedge clk);
      #1;
      assert (cs_n == '1) else begin
         errors++;
         $display("ERROR %0t cs_n: got %b expected %b", $time, cs_n, {NCH{1'b1}});
      end
      assert (sclk == 1'b0) else begin
         errors++;
         $display("ERROR %0t sclk: got %b expected 0", $time, sclk);
      end
      assert (wait_out == 1'b0) else begin
         errors++;
         $display("ERROR %0t wait_out: got %b expected 0", $time, wait_out);
      end
      test_done("reset state", err0);

      err0 = errors;
      for (int dm = 0; dm < 4; dm++) begin                 // 1, 2, 4, 8 bytes
         send(1'b1, 1'b1, 6'h10, 0, 2'(dm), $urandom, $urandom);
         idle();
      end
      drain();
      test_done("byte order on channel 0", err0);

      err0   = errors;
      falls0 = cs_falls;
      for (int i = 0; i < 2; i++) begin
         send(1'b0, 1'b1, 6'h10, i, 2'd3, $urandom, $urandom);   // Disabled
         send(1'b1, 1'b0, 6'h10, i, 2'd3, $urandom, $urandom);   // Read
         send(1'b1, 1'b1, 6'h11, i, 2'd3, $urandom, $urandom);   // Wrong register
      end
      idle();
      repeat (100) @(posedge clk);
      #1;
      assert (cs_falls == falls0) else begin
         errors++;
         $display("Dropped packets still produced SPI traffic");
      end
      test_done("filtering", err0);

      err0 = errors;
      repeat (40) rand_send(1'b0);                         // All channels, back to back
      drain();
      test_done("routing and fairness", err0);

      err0    = errors;
      stalled = 1'b0;
      repeat (6) send(1'b1, 1'b1, 6'h10, 1, 2'd3, $urandom, $urandom);
      drain();
      assert (stalled) else begin
         errors++;
         $display("wait_out never rose during the burst");
      end
      assert (pending() == 0) else begin
         errors++;
         $display("Bytes left in the model after the burst");
      end
      test_done("back-pressure", err0);

      err0 = errors;
      repeat (200) begin
         rand_send(1'b1);
         if (($urandom % 4) == 0) begin
            idle();
         end
      end
      drain();
      assert (pending() == 0) else begin
         errors++;
         $display("Bytes left in the model after mixed traffic");
      end
      test_done("mixed random traffic", err0);

      $display("Tests run %0d, bytes checked %0d, errors %0d", tests, bytes_checked, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: spi_pkg.sv
`default_nettype none

package spi_pkg;

   //############################################################
   // Widths
   //############################################################
   localparam int AW  = 32;          // Address and data width
   localparam int PW  = 2*AW + 40;   // Mesh packet, 104 bits
   localparam int SW  = 8;           // SPI byte
   localparam int TXW = 2*AW;        // srcaddr above data
   localparam int DSW = 4;           // Byte count 1..8

   //############################################################
   // Packet layout, bit offsets
   //############################################################
   localparam int WR_LSB   = 0;                 // write
   localparam int DM_LSB   = WR_LSB + 1;        // datamode
   localparam int DM_W     = 2;
   localparam int CM_LSB   = DM_LSB + DM_W;     // ctrlmode
   localparam int CM_W     = 5;
   localparam int DST_LSB  = CM_LSB + CM_W;     // dstaddr
   localparam int SRC_LSB  = DST_LSB + AW;      // srcaddr
   localparam int DATA_LSB = SRC_LSB + AW;      // data

   // TX data register, matched on dstaddr[5:0]
   localparam logic [5:0] SPI_TX = 6'h10;
   localparam int CH_LSB = 8;                   // Channel select in dstaddr

   // Channel index width, never zero
   function automatic int ch_bits(input int n);
      return (n > 1) ? $clog2(n) : 1;
   endfunction

endpackage

`default_nettype wire

// File: spi_shift_engine.sv
`default_nettype none

module spi_shift_engine #(
   parameter int NCH    = 4,
   parameter int CLKDIV = 2
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic [NCH-1:0]           fifo_empty,
   input  logic [spi_pkg::SW-1:0]   fifo_dout [NCH],
   output logic [NCH-1:0]           fifo_read,
   output logic                     sclk,
   output logic                     mosi,
   output logic [NCH-1:0]           cs_n
);

   localparam int CHW = spi_pkg::ch_bits(NCH);
   localparam int DVW = $clog2(CLKDIV + 1);

   // IDLE is also the gap clk between bytes, all cs_n high
   typedef enum logic [1:0] {
      IDLE,
      SEL,
      SHIFT
   } state_t;

   state_t                    state;
   logic [CHW-1:0]            last;       // Last channel served
   logic [CHW-1:0]            pick;
   logic                      any;
   logic [DVW-1:0]            div_cnt;
   logic [3:0]                half_cnt;   // 16 SCLK half periods
   logic                      half_end;
   logic [spi_pkg::SW-1:0]    shreg;

   assign half_end = (div_cnt == DVW'(CLKDIV - 1));

   //############################################################
   // Round-robin pick
   //############################################################
   always_comb begin
      int idx;
      idx  = 0;
      any  = 1'b0;
      pick = last;
      for (int i = 1; i <= NCH; i++) begin
         idx = (int'(last) + i) % NCH;     // Start just after last
         if (!any && !fifo_empty[idx]) begin
            any  = 1'b1;
            pick = CHW'(idx);
         end
      end
   end

   always_comb begin
      fifo_read = '0;
      if (state == IDLE && any) begin
         fifo_read[pick] = 1'b1;           // Pop in the grant cycle
      end
   end

   //############################################################
   // Mode 0 shifter
   //############################################################
   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= IDLE;
         last     <= CHW'(NCH - 1);        // Channel 0 gets first turn
         sclk     <= 1'b0;
         mosi     <= 1'b0;
         cs_n     <= '1;
         div_cnt  <= '0;
         half_cnt <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (any) begin
                  last       <= pick;
                  cs_n[pick] <= 1'b0;
                  mosi       <= fifo_dout[pick][spi_pkg::SW-1];  // MSB set up
                  state      <= SEL;
               end
            end
            SEL: begin
               sclk     <= 1'b1;           // First rise, one clk after cs_n
               div_cnt  <= '0;
               half_cnt <= '0;
               state    <= SHIFT;
            end
            SHIFT: begin
               div_cnt <= half_end ? '0 : div_cnt + 1'b1;
               if (half_end) begin
                  half_cnt <= half_cnt + 1'b1;
                  if (!half_cnt[0]) begin
                     sclk <= 1'b0;                     // Fall, next bit out
                     mosi <= shreg[spi_pkg::SW-2];
                  end else if (half_cnt == 4'd15) begin
                     cs_n  <= '1;                      // After the 8th fall
                     mosi  <= 1'b0;
                     state <= IDLE;
                  end else begin
                     sclk <= 1'b1;
                  end
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Byte in flight, moves up at every fall
   always_ff @(posedge clk) begin
      if (state == IDLE && any) begin
         shreg <= fifo_dout[pick];
      end else if (state == SHIFT && half_end && !half_cnt[0]) begin
         shreg <= shreg << 1;
      end
   end

endmodule

`default_nettype wire

// File: spi_tx_channel.sv
`default_nettype none

module spi_tx_channel #(
   parameter int DEPTH = 16
) (
   input  logic                     clk,
   input  logic                     rst,
   spi_load_if.channel              ld,
   input  logic                     fifo_read,
   output logic                     fifo_empty,
   output logic [spi_pkg::SW-1:0]   fifo_dout
);

   localparam int PTRW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNTW = $clog2(DEPTH + 1);

   logic [spi_pkg::TXW-1:0]   shreg;      // Pending payload
   logic [spi_pkg::DSW-1:0]   left;       // Bytes still to push
   logic                      wr_en;
   logic                      rd_en;
   logic                      prog_full;

   logic [spi_pkg::SW-1:0]    mem [DEPTH];
   logic [PTRW-1:0]           wr_ptr;
   logic [PTRW-1:0]           rd_ptr;
   logic [CNTW-1:0]           count;      // Occupancy

   // Wrap for any depth
   function automatic logic [PTRW-1:0] next_ptr(input logic [PTRW-1:0] p);
      return (p == PTRW'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   //############################################################
   // Parallel to serial
   //############################################################
   assign ld.busy = (left != '0);
   assign wr_en   = ld.busy & ~prog_full;  // Stall on prog_full, busy stretches

   always_ff @(posedge clk) begin
      if (rst) begin
         left <= '0;
      end else if (ld.load) begin
         left <= ld.datasize;              // Decoder only loads when idle
      end else if (wr_en) begin
         left <= left - 1'b1;
      end
   end

   // LSB first, drop one byte per write
   always_ff @(posedge clk) begin
      if (ld.load) begin
         shreg <= ld.tx_data;
      end else if (wr_en) begin
         shreg <= shreg >> spi_pkg::SW;
      end
   end

   //############################################################
   // Byte FIFO, show-ahead
   //############################################################
   assign fifo_empty = (count == '0);
   assign prog_full  = (count >= CNTW'(DEPTH - 1));
   assign rd_en      = fifo_read & ~fifo_empty;
   assign fifo_dout  = mem[rd_ptr];        // Head visible before the pop

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= shreg[spi_pkg::SW-1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (rd_en) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;       // Both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

// File: spi_tx_decode.sv
`default_nettype none

module spi_tx_decode #(
   parameter int NCH = 4
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     spi_en,
   input  logic                     access_in,
   input  logic [spi_pkg::PW-1:0]   packet_in,
   output logic                     wait_out,
   spi_load_if.decoder              ld [NCH]
);

   localparam int CHW = spi_pkg::ch_bits(NCH);

   logic                         write_in;
   logic [spi_pkg::DM_W-1:0]     datamode_in;
   logic [spi_pkg::AW-1:0]       dstaddr_in;
   logic [spi_pkg::AW-1:0]       srcaddr_in;
   logic [spi_pkg::AW-1:0]       data_in;
   logic [spi_pkg::DSW-1:0]      datasize;
   logic [spi_pkg::TXW-1:0]      tx_data;
   logic [CHW-1:0]               ch;
   logic                         tx_hit;
   logic                         accept;
   logic [NCH-1:0]               busy_vec;
   logic [NCH-1:0]               load_vec;
   logic [NCH-1:0]               ld_q;

   //############################################################
   // Packet fields
   //############################################################
   assign write_in    = packet_in[spi_pkg::WR_LSB];
   assign datamode_in = packet_in[spi_pkg::DM_LSB +: spi_pkg::DM_W];
   assign dstaddr_in  = packet_in[spi_pkg::DST_LSB +: spi_pkg::AW];
   assign srcaddr_in  = packet_in[spi_pkg::SRC_LSB +: spi_pkg::AW];
   assign data_in     = packet_in[spi_pkg::DATA_LSB +: spi_pkg::AW];

   // 1, 2, 4 or 8 bytes
   assign datasize = spi_pkg::DSW'(1) << datamode_in;
   assign tx_data  = {srcaddr_in, data_in};  // data bytes leave first

   // Channel field, NCH assumed a power of two
   assign ch = dstaddr_in[spi_pkg::CH_LSB +: CHW];

   //############################################################
   // Qualify and steer
   //############################################################
   // Anything else on the bus is silently dropped
   assign tx_hit = spi_en & write_in & (dstaddr_in[5:0] == spi_pkg::SPI_TX);

   assign accept   = access_in & tx_hit & ~busy_vec[ch];
   assign wait_out = access_in & tx_hit & busy_vec[ch];  // Only the addressed channel stalls

   for (genvar g = 0; g < NCH; g++) begin : g_ld
      assign load_vec[g]    = accept & (ch == CHW'(g));
      assign ld[g].load     = load_vec[g];
      assign ld[g].datasize = datasize;
      assign ld[g].tx_data  = tx_data;
      assign busy_vec[g]    = ld[g].busy | ld_q[g];  // Cover the load cycle itself
   end

   // Loads of the previous cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         ld_q <= '0;
      end else begin
         ld_q <= load_vec;
      end
   end

endmodule

`default_nettype wire

// File: verilog.f
spi_pkg.sv
spi_load_if.sv
spi_tx_decode.sv
spi_tx_channel.sv
spi_shift_engine.sv
spi_master_tx.sv
spi_master_tx_tb.sv
